//--- hdl/extmem_pkg.sv
/*
 * External memory port shared definitions
 * Widths, channel payload structs, region table entry and error codes
 * used across the tagged load/store port.
 */
package extmem_pkg;

  // ----------------------------------------------------------------------
  // Field widths
  // ----------------------------------------------------------------------
  localparam int TAG_W  = 2;
  localparam int MEM_AW = 8;
  localparam int ELEM_W = 32;

  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [MEM_AW-1:0] mem_addr_t;
  typedef logic [ELEM_W-1:0] elem_t;

  // ----------------------------------------------------------------------
  // Channel payloads
  // ----------------------------------------------------------------------

  // Load address and store address channels
  typedef struct packed {
    tag_t      tag;
    mem_addr_t addr;
  } addr_req_t;

  // Store data channel
  typedef struct packed {
    tag_t  tag;
    elem_t data;
  } st_data_t;

  // Load response carrying the tag back with the element
  typedef struct packed {
    tag_t  tag;
    elem_t data;
  } ld_resp_t;

  // Region table entry with an exclusive end_tag
  typedef struct packed {
    logic      valid;
    tag_t      start_tag;
    tag_t      end_tag;
    mem_addr_t offset;
  } region_t;

  // Paired store going to the memory
  typedef struct packed {
    mem_addr_t addr;
    elem_t     data;
  } mem_wr_t;

  // ----------------------------------------------------------------------
  // Runtime error codes
  // ----------------------------------------------------------------------
  typedef enum logic [15:0] {
    ERR_NONE           = 16'd0,
    ERR_TAG_OOB        = 16'd1,
    ERR_NO_MATCH       = 16'd2,
    ERR_STORE_DEADLOCK = 16'd3
  } err_code_e;

endpackage

//--- hdl/tag_queue.sv
/*
 * Tag queue
 * Circular FIFO of generic payload with simultaneous push and pop.
 */
module tag_queue #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     full,
  output logic     empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         slots [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (count == CNT_W'(DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign head    = slots[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Occupancy holds when both happen together
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Payload storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      slots[wr_ptr] <= push_data;
    end
  end

endmodule

//--- hdl/region_map.sv
/*
 * Region map
 * Finds the region table entry covering a tag and returns its offset.
 */
module region_map
  import extmem_pkg::*;
#(
  parameter int NUM_REGION = 2
) (
  input  region_t   regions [NUM_REGION],
  input  tag_t      tag,
  output logic      match,
  output mem_addr_t offset
);

  logic [NUM_REGION-1:0] hit;

  // ----------------------------------------------------------------------
  // Per-entry range compare
  // ----------------------------------------------------------------------
  always_comb begin
    for (int r = 0; r < NUM_REGION; r++) begin
      hit[r] = regions[r].valid &&
               (tag >= regions[r].start_tag) &&
               (tag < regions[r].end_tag);
    end
  end

  // ----------------------------------------------------------------------
  // Later matching entries override earlier ones
  // ----------------------------------------------------------------------
  always_comb begin
    match  = 1'b0;
    offset = '0;
    for (int r = 0; r < NUM_REGION; r++) begin
      if (hit[r]) begin
        match  = 1'b1;
        offset = regions[r].offset;
      end
    end
  end

endmodule

//--- hdl/pair_watchdog.sv
/*
 * Store pairing watchdog
 * Counts cycles spent with only one store half queued for a tag.
 */
module pair_watchdog #(
  parameter int DEADLOCK_TIMEOUT = 64
) (
  input  logic clk,
  input  logic rst_n,
  input  logic one_sided,
  output logic stuck
);

  localparam int CNT_W = $clog2(DEADLOCK_TIMEOUT + 1);

  logic [CNT_W-1:0] wait_cnt;

  assign stuck = (wait_cnt == CNT_W'(DEADLOCK_TIMEOUT));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_cnt <= '0;
    end else if (!one_sided) begin
      // Halves balanced again
      wait_cnt <= '0;
    end else if (!stuck) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

endmodule

//--- hdl/store_pairing.sv
/*
 * Store pairing
 * Queues store address and data halves per tag, grants the lowest tag
 * holding both halves and issues the paired memory write.
 */
module store_pairing
  import extmem_pkg::*;
#(
  parameter int ST_COUNT         = 4,
  parameter int LSQ_DEPTH        = 4,
  parameter int DEADLOCK_TIMEOUT = 64
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      st_addr_valid,
  output logic      st_addr_ready,
  input  addr_req_t st_addr,
  input  logic      st_addr_ok,
  input  logic      st_data_valid,
  output logic      st_data_ready,
  input  st_data_t  st_data,
  input  logic      st_data_ok,
  output logic      st_done_valid,
  input  logic      st_done_ready,
  output tag_t      st_done_tag,
  output logic      mem_wr_valid,
  output mem_wr_t   mem_wr,
  output logic      deadlock
);

  logic [ST_COUNT-1:0] addr_full;
  logic [ST_COUNT-1:0] addr_empty;
  logic [ST_COUNT-1:0] data_full;
  logic [ST_COUNT-1:0] data_empty;
  logic [ST_COUNT-1:0] addr_push;
  logic [ST_COUNT-1:0] data_push;
  logic [ST_COUNT-1:0] pair_req;
  logic [ST_COUNT-1:0] pair_pop;
  logic [ST_COUNT-1:0] stuck;
  mem_addr_t           addr_head [ST_COUNT];
  elem_t               data_head [ST_COUNT];
  logic                done_fire;

  // ----------------------------------------------------------------------
  // Ready from the addressed queue only, never from valid
  // ----------------------------------------------------------------------
  always_comb begin
    st_addr_ready = 1'b0;
    st_data_ready = 1'b0;
    for (int t = 0; t < ST_COUNT; t++) begin
      if (st_addr.tag == tag_t'(t)) begin
        st_addr_ready = st_addr_ok && !addr_full[t];
      end
      if (st_data.tag == tag_t'(t)) begin
        st_data_ready = st_data_ok && !data_full[t];
      end
    end
  end

  // ----------------------------------------------------------------------
  // Per-tag queues and watchdogs
  // ----------------------------------------------------------------------
  for (genvar t = 0; t < ST_COUNT; t++) begin : g_tag
    assign addr_push[t] = st_addr_valid && st_addr_ready && (st_addr.tag == tag_t'(t));
    assign data_push[t] = st_data_valid && st_data_ready && (st_data.tag == tag_t'(t));
    assign pair_req[t]  = !addr_empty[t] && !data_empty[t];
    assign pair_pop[t]  = done_fire && (st_done_tag == tag_t'(t));

    tag_queue #(.payload_t(mem_addr_t), .DEPTH(LSQ_DEPTH)) u_addr_q (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (addr_push[t]),
      .push_data (st_addr.addr),
      .pop       (pair_pop[t]),
      .head      (addr_head[t]),
      .full      (addr_full[t]),
      .empty     (addr_empty[t])
    );

    tag_queue #(.payload_t(elem_t), .DEPTH(LSQ_DEPTH)) u_data_q (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (data_push[t]),
      .push_data (st_data.data),
      .pop       (pair_pop[t]),
      .head      (data_head[t]),
      .full      (data_full[t]),
      .empty     (data_empty[t])
    );

    // One half waiting without its partner
    pair_watchdog #(.DEADLOCK_TIMEOUT(DEADLOCK_TIMEOUT)) u_watchdog (
      .clk       (clk),
      .rst_n     (rst_n),
      .one_sided (addr_empty[t] != data_empty[t]),
      .stuck     (stuck[t])
    );
  end

  // ----------------------------------------------------------------------
  // Lowest requesting tag wins the done channel
  // ----------------------------------------------------------------------
  always_comb begin : pick_lowest
    logic found;
    found       = 1'b0;
    st_done_tag = '0;
    mem_wr      = '0;
    for (int t = 0; t < ST_COUNT; t++) begin
      if (!found && pair_req[t]) begin
        found       = 1'b1;
        st_done_tag = tag_t'(t);
        mem_wr      = '{addr: addr_head[t], data: data_head[t]};
      end
    end
  end

  assign st_done_valid = |pair_req;
  assign done_fire     = st_done_valid && st_done_ready;
  assign mem_wr_valid  = done_fire;
  assign deadlock      = |stuck;

endmodule

//--- hdl/mem_array.sv
/*
 * Behavioral external memory
 * 256 words, combinational read port, clocked write port.
 */
module mem_array
  import extmem_pkg::*;
(
  input  logic      clk,
  input  mem_addr_t rd_addr,
  output elem_t     rd_data,
  input  logic      mem_wr_valid,
  input  mem_wr_t   mem_wr
);

  localparam int NUM_WORDS = 2 ** MEM_AW;

  elem_t words [NUM_WORDS];

  // Load path sees the word immediately
  assign rd_data = words[rd_addr];

  // Paired store lands on the done handshake edge
  always_ff @(posedge clk) begin
    if (mem_wr_valid) begin
      words[mem_wr.addr] <= mem_wr.data;
    end
  end

endmodule

//--- hdl/error_monitor.sv
/*
 * Error monitor
 * Prioritizes runtime error conditions and holds the first one seen.
 */
module error_monitor
  import extmem_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      tag_oob,
  input  logic      no_match,
  input  logic      deadlock,
  output logic      error_valid,
  output err_code_e error_code
);

  logic      err_hit;
  err_code_e next_code;

  // Tag range outranks region, region outranks deadlock
  always_comb begin
    err_hit   = 1'b1;
    next_code = ERR_NONE;
    if (tag_oob) begin
      next_code = ERR_TAG_OOB;
    end else if (no_match) begin
      next_code = ERR_NO_MATCH;
    end else if (deadlock) begin
      next_code = ERR_STORE_DEADLOCK;
    end else begin
      err_hit = 1'b0;
    end
  end

  // Sticky until reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      error_valid <= 1'b0;
      error_code  <= ERR_NONE;
    end else if (!error_valid && err_hit) begin
      error_valid <= 1'b1;
      error_code  <= next_code;
    end
  end

endmodule

//--- hdl/extmem_top.sv
/*
 * External memory port top level
 * Zero-latency tagged loads, paired tagged stores, region offsets
 * and sticky runtime error reporting.
 */
module extmem_top
  import extmem_pkg::*;
#(
  parameter int LD_COUNT         = 3,
  parameter int ST_COUNT         = 4,
  parameter int LSQ_DEPTH        = 4,
  parameter int DEADLOCK_TIMEOUT = 64,
  parameter int NUM_REGION       = 2
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      ld_addr_valid,
  output logic      ld_addr_ready,
  input  addr_req_t ld_addr,
  output logic      ld_resp_valid,
  input  logic      ld_resp_ready,
  output ld_resp_t  ld_resp,
  input  logic      st_addr_valid,
  output logic      st_addr_ready,
  input  addr_req_t st_addr,
  input  logic      st_data_valid,
  output logic      st_data_ready,
  input  st_data_t  st_data,
  output logic      st_done_valid,
  input  logic      st_done_ready,
  output tag_t      st_done_tag,
  input  region_t   regions [NUM_REGION],
  output logic      error_valid,
  output err_code_e error_code
);

  logic      ld_oob;
  logic      st_addr_oob;
  logic      st_data_oob;
  logic      ld_match;
  logic      st_match;
  mem_addr_t ld_offset;
  mem_addr_t st_offset;
  mem_addr_t rd_addr;
  elem_t     rd_data;
  addr_req_t st_addr_mapped;
  logic      mem_wr_valid;
  mem_wr_t   mem_wr;
  logic      deadlock;
  logic      err_tag_oob;
  logic      err_no_match;

  // ----------------------------------------------------------------------
  // Tag range checks
  // ----------------------------------------------------------------------
  assign ld_oob      = int'(ld_addr.tag) >= LD_COUNT;
  assign st_addr_oob = int'(st_addr.tag) >= ST_COUNT;
  assign st_data_oob = int'(st_data.tag) >= ST_COUNT;

  region_map #(.NUM_REGION(NUM_REGION)) u_ld_map (
    .regions (regions),
    .tag     (ld_addr.tag),
    .match   (ld_match),
    .offset  (ld_offset)
  );

  region_map #(.NUM_REGION(NUM_REGION)) u_st_map (
    .regions (regions),
    .tag     (st_addr.tag),
    .match   (st_match),
    .offset  (st_offset)
  );

  // ----------------------------------------------------------------------
  // Load path answered in the request cycle
  // ----------------------------------------------------------------------
  assign rd_addr       = ld_addr.addr + ld_offset;
  assign ld_resp_valid = ld_addr_valid && !ld_oob;
  assign ld_addr_ready = ld_resp_ready && !ld_oob;
  assign ld_resp       = '{tag: ld_addr.tag, data: rd_data};

  mem_array u_mem (
    .clk          (clk),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .mem_wr_valid (mem_wr_valid),
    .mem_wr       (mem_wr)
  );

  // ----------------------------------------------------------------------
  // Store path
  // ----------------------------------------------------------------------
  assign st_addr_mapped = '{tag: st_addr.tag, addr: st_addr.addr + st_offset};

  store_pairing #(
    .ST_COUNT         (ST_COUNT),
    .LSQ_DEPTH        (LSQ_DEPTH),
    .DEADLOCK_TIMEOUT (DEADLOCK_TIMEOUT)
  ) u_pairing (
    .clk           (clk),
    .rst_n         (rst_n),
    .st_addr_valid (st_addr_valid),
    .st_addr_ready (st_addr_ready),
    .st_addr       (st_addr_mapped),
    .st_addr_ok    (!st_addr_oob),
    .st_data_valid (st_data_valid),
    .st_data_ready (st_data_ready),
    .st_data       (st_data),
    .st_data_ok    (!st_data_oob),
    .st_done_valid (st_done_valid),
    .st_done_ready (st_done_ready),
    .st_done_tag   (st_done_tag),
    .mem_wr_valid  (mem_wr_valid),
    .mem_wr        (mem_wr),
    .deadlock      (deadlock)
  );

  // ----------------------------------------------------------------------
  // Error conditions
  // ----------------------------------------------------------------------
  assign err_tag_oob  = (ld_addr_valid && ld_oob) ||
                        (st_addr_valid && st_addr_oob) ||
                        (st_data_valid && st_data_oob);
  assign err_no_match = (ld_addr_valid && !ld_oob && !ld_match) ||
                        (st_addr_valid && !st_addr_oob && !st_match);

  error_monitor u_err (
    .clk         (clk),
    .rst_n       (rst_n),
    .tag_oob     (err_tag_oob),
    .no_match    (err_no_match),
    .deadlock    (deadlock),
    .error_valid (error_valid),
    .error_code  (error_code)
  );

endmodule

//--- test/extmem_tb.sv
/*
 * Testbench for the external memory port
 * Drives tagged loads and paired stores, keeps a reference memory and
 * checks responses, pairing order, back-pressure and error codes.
 */
module extmem_tb
  import extmem_pkg::*;
;

  localparam int LD_COUNT         = 3;
  localparam int ST_COUNT         = 4;
  localparam int LSQ_DEPTH        = 4;
  localparam int DEADLOCK_TIMEOUT = 64;
  localparam int NUM_REGION       = 2;
  localparam int NUM_STORES       = 8;

  logic      clk;
  logic      rst_n;
  logic      ld_addr_valid;
  logic      ld_addr_ready;
  addr_req_t ld_addr;
  logic      ld_resp_valid;
  logic      ld_resp_ready;
  ld_resp_t  ld_resp;
  logic      st_addr_valid;
  logic      st_addr_ready;
  addr_req_t st_addr;
  logic      st_data_valid;
  logic      st_data_ready;
  st_data_t  st_data;
  logic      st_done_valid;
  logic      st_done_ready;
  tag_t      st_done_tag;
  region_t   regions [NUM_REGION];
  logic      error_valid;
  err_code_e error_code;

  // Reference state
  elem_t     ref_mem [256];
  mem_addr_t pend_addr [ST_COUNT][16];
  elem_t     pend_data [ST_COUNT][16];
  int        a_wr [ST_COUNT];
  int        a_rd [ST_COUNT];
  int        d_wr [ST_COUNT];
  int        d_rd [ST_COUNT];
  tag_t      exp_done_q [$];
  int        loads_seen;
  int        done_tag;
  ld_resp_t  exp_resp;
  logic [31:0] lfsr_state;
  tag_t      log_tag [NUM_STORES];
  mem_addr_t log_addr [NUM_STORES];
  int        accepted;
  int        accepted_data;

  extmem_top #(
    .LD_COUNT         (LD_COUNT),
    .ST_COUNT         (ST_COUNT),
    .LSQ_DEPTH        (LSQ_DEPTH),
    .DEADLOCK_TIMEOUT (DEADLOCK_TIMEOUT),
    .NUM_REGION       (NUM_REGION)
  ) extmem_top_inst (
    .clk (clk), .rst_n (rst_n),
    .ld_addr_valid (ld_addr_valid), .ld_addr_ready (ld_addr_ready), .ld_addr (ld_addr),
    .ld_resp_valid (ld_resp_valid), .ld_resp_ready (ld_resp_ready), .ld_resp (ld_resp),
    .st_addr_valid (st_addr_valid), .st_addr_ready (st_addr_ready), .st_addr (st_addr),
    .st_data_valid (st_data_valid), .st_data_ready (st_data_ready), .st_data (st_data),
    .st_done_valid (st_done_valid), .st_done_ready (st_done_ready),
    .st_done_tag (st_done_tag), .regions (regions),
    .error_valid (error_valid), .error_code (error_code)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // ----------------------------------------------------------------------
  // Failure reporting and compare tasks
  // ----------------------------------------------------------------------
  task automatic abort_run;
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    abort_run();
  endtask

  task automatic check_resp(input string name, input ld_resp_t exp, input ld_resp_t act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_tag(input string name, input tag_t exp, input tag_t act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_err(input string name, input err_code_e exp, input err_code_e act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hA3000000) : (lfsr_state >> 1);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Tags 0 and 1 sit at 16, tag 2 at 64, tag 3 is unmapped
  function automatic mem_addr_t region_offset(input tag_t tag);
    if (tag < 2) begin
      return 8'd16;
    end else if (tag == 2) begin
      return 8'd64;
    end
    return 8'd0;
  endfunction

  function automatic elem_t expected_load(input tag_t tag, input mem_addr_t addr);
    mem_addr_t eff;
    eff = addr + region_offset(tag);
    return ref_mem[eff];
  endfunction

  // Compare process sampled mid-cycle where outputs are settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (ld_resp_valid && ld_resp_ready) begin
        exp_resp.tag  = ld_addr.tag;
        exp_resp.data = expected_load(ld_addr.tag, ld_addr.addr);
        check_resp("load_response", exp_resp, ld_resp);
        loads_seen++;
      end
      if (st_done_valid && st_done_ready) begin
        done_tag = st_done_tag;
        ref_mem[pend_addr[done_tag][a_rd[done_tag] % 16]] =
          pend_data[done_tag][d_rd[done_tag] % 16];
        a_rd[done_tag]++;
        d_rd[done_tag]++;
        if (exp_done_q.size() > 0) begin
          check_tag("pairing_order", exp_done_q.pop_front(), st_done_tag);
        end
      end
      if (st_addr_valid && st_addr_ready) begin
        pend_addr[st_addr.tag][a_wr[st_addr.tag] % 16] =
          st_addr.addr + region_offset(st_addr.tag);
        a_wr[st_addr.tag]++;
      end
      if (st_data_valid && st_data_ready) begin
        pend_data[st_data.tag][d_wr[st_data.tag] % 16] = st_data.data;
        d_wr[st_data.tag]++;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus tasks that all return 2 units after a rising edge
  // ----------------------------------------------------------------------
  task automatic apply_reset;
    rst_n         = 1'b0;
    ld_addr_valid = 1'b0;
    ld_addr       = '0;
    ld_resp_ready = 1'b1;
    st_addr_valid = 1'b0;
    st_addr       = '0;
    st_data_valid = 1'b0;
    st_data       = '0;
    st_done_ready = 1'b1;
    for (int t = 0; t < ST_COUNT; t++) begin
      a_wr[t] = 0;
      a_rd[t] = 0;
      d_wr[t] = 0;
      d_rd[t] = 0;
    end
    exp_done_q.delete();
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
  endtask

  task automatic send_addr(input tag_t req_tag, input mem_addr_t req_addr);
    int   waited;
    logic took;
    st_addr_valid = 1'b1;
    st_addr       = '{tag: req_tag, addr: req_addr};
    took          = 1'b0;
    waited        = 0;
    while (!took) begin
      @(negedge clk);
      took = st_addr_ready;
      waited++;
      if (!took && waited >= 500) begin
        report_problem("store address was not accepted within 500 cycles");
      end
      @(posedge clk);
      #2;
    end
    st_addr_valid = 1'b0;
  endtask

  task automatic send_data(input tag_t req_tag, input elem_t req_data);
    int   waited;
    logic took;
    st_data_valid = 1'b1;
    st_data       = '{tag: req_tag, data: req_data};
    took          = 1'b0;
    waited        = 0;
    while (!took) begin
      @(negedge clk);
      took = st_data_ready;
      waited++;
      if (!took && waited >= 500) begin
        report_problem("store data was not accepted within 500 cycles");
      end
      @(posedge clk);
      #2;
    end
    st_data_valid = 1'b0;
  endtask

  task automatic send_load(input tag_t req_tag, input mem_addr_t req_addr);
    int   waited;
    logic took;
    ld_addr_valid = 1'b1;
    ld_addr       = '{tag: req_tag, addr: req_addr};
    took          = 1'b0;
    waited        = 0;
    while (!took) begin
      @(negedge clk);
      took = ld_addr_ready;
      waited++;
      if (!took && waited >= 500) begin
        report_problem("load request was not accepted within 500 cycles");
      end
      @(posedge clk);
      #2;
    end
    ld_addr_valid = 1'b0;
  endtask

  // Waits until every queued pair has been written
  task automatic wait_pairs_drained;
    int waited;
    waited = 0;
    @(negedge clk);
    while (st_done_valid || exp_done_q.size() > 0) begin
      waited++;
      if (waited >= 500) begin
        report_problem("store pairs did not drain within 500 cycles");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #2;
  endtask

  task automatic wait_error;
    int waited;
    waited = 0;
    @(negedge clk);
    while (!error_valid) begin
      waited++;
      if (waited >= 500) begin
        report_problem("error_valid did not rise within 500 cycles");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #2;
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    lfsr_state = 32'h47c7ef10;
    loads_seen = 0;
    regions[0] = '{valid: 1'b1, start_tag: 2'd0, end_tag: 2'd2, offset: 8'd16};
    regions[1] = '{valid: 1'b1, start_tag: 2'd2, end_tag: 2'd3, offset: 8'd64};
    apply_reset();

    // Store then load
    for (int i = 0; i < NUM_STORES; i++) begin
      log_tag[i]  = tag_t'(rand_bits(2) % 3);
      log_addr[i] = mem_addr_t'(rand_bits(8));
      send_addr(log_tag[i], log_addr[i]);
      send_data(log_tag[i], elem_t'(rand_bits(32)));
    end
    wait_pairs_drained();
    for (int i = 0; i < NUM_STORES; i++) begin
      send_load(log_tag[i], log_addr[i]);
    end
    check_count("store_load_count", NUM_STORES, loads_seen);
    check_err("store_load_code", ERR_NONE, error_code);
    if (error_valid !== 1'b0) begin
      report_problem("error_valid rose during plain stores and loads");
    end

    // Pairing order, data ahead of addresses
    apply_reset();
    st_done_ready = 1'b0;
    send_data(2'd2, elem_t'(rand_bits(32)));
    send_data(2'd0, elem_t'(rand_bits(32)));
    send_data(2'd1, elem_t'(rand_bits(32)));
    send_addr(2'd2, mem_addr_t'(rand_bits(8)));
    send_addr(2'd0, mem_addr_t'(rand_bits(8)));
    send_addr(2'd1, mem_addr_t'(rand_bits(8)));
    exp_done_q = '{2'd0, 2'd1, 2'd2};
    st_done_ready = 1'b1;
    wait_pairs_drained();

    // Store back-pressure on tag 1, then a stalled load
    apply_reset();
    st_done_ready = 1'b0;
    accepted      = 0;
    accepted_data = 0;
    for (int i = 0; i < LSQ_DEPTH + 2; i++) begin
      st_addr_valid = 1'b1;
      st_addr       = '{tag: 2'd1, addr: mem_addr_t'(rand_bits(8))};
      st_data_valid = 1'b1;
      st_data       = '{tag: 2'd1, data: elem_t'(rand_bits(32))};
      @(negedge clk);
      if (st_addr_ready) begin
        accepted++;
      end
      if (st_data_ready) begin
        accepted_data++;
      end
      @(posedge clk);
      #2;
    end
    st_addr_valid = 1'b0;
    st_data_valid = 1'b0;
    check_count("backpressure_addr_count", LSQ_DEPTH, accepted);
    check_count("backpressure_data_count", LSQ_DEPTH, accepted_data);
    ld_resp_ready = 1'b0;
    ld_addr_valid = 1'b1;
    ld_addr       = '{tag: log_tag[0], addr: log_addr[0]};
    repeat (3) begin
      @(negedge clk);
      if (ld_addr_ready !== 1'b0) begin
        report_problem("load was accepted while ld_resp_ready was low");
      end
      @(posedge clk);
      #2;
    end
    ld_resp_ready = 1'b1;
    @(posedge clk);
    #2;
    ld_addr_valid = 1'b0;

    // Load with tag 3 is out of range
    apply_reset();
    ld_addr_valid = 1'b1;
    ld_addr       = '{tag: 2'd3, addr: 8'h10};
    repeat (3) begin
      @(negedge clk);
      if (ld_addr_ready !== 1'b0 || ld_resp_valid !== 1'b0) begin
        report_problem("out of range load was accepted or answered");
      end
      @(posedge clk);
      #2;
    end
    wait_error();
    ld_addr_valid = 1'b0;
    check_err("tag_out_of_range", ERR_TAG_OOB, error_code);

    // Store address on an unmapped tag
    apply_reset();
    send_addr(2'd3, mem_addr_t'(rand_bits(8)));
    wait_error();
    check_err("no_matching_region", ERR_NO_MATCH, error_code);

    // Address half left alone on tag 0
    apply_reset();
    send_addr(2'd0, mem_addr_t'(rand_bits(8)));
    repeat (DEADLOCK_TIMEOUT + 2) @(posedge clk);
    @(negedge clk);
    if (error_valid !== 1'b1) begin
      report_problem("error_valid was not set after the store watchdog limit");
    end
    check_err("store_deadlock", ERR_STORE_DEADLOCK, error_code);

    $display("No errors");
    $finish;
  end

endmodule

//--- flist.f
hdl/extmem_pkg.sv
hdl/tag_queue.sv
hdl/region_map.sv
hdl/pair_watchdog.sv
hdl/store_pairing.sv
hdl/mem_array.sv
hdl/error_monitor.sv
hdl/extmem_top.sv
test/extmem_tb.sv
